// ==== source/flc_pkg.sv ====
/*
 * FlexConnect example shared definitions
 * Client stream format, gateway memory geometry and the
 * two views of the 72-bit user sideband
 */
package flc_pkg;

  // Client stream format fixed by the connect block
  localparam int DATA_W = 512;
  localparam int KEEP_W = DATA_W / 8;
  localparam int USER_W = 72;

  // Gateway memory
  localparam int GW_WORDS  = 1024;
  localparam int GW_ADDR_W = $clog2(GW_WORDS);

  // APB address as wide as the connect block issues
  localparam int APB_ADDR_W = 64;
  localparam int APB_DATA_W = 32;

  // Sideband bit copied into the flag on loopback
  localparam int QUEUE_CLEAR_BIT = 56;

  // Sideband word seen raw or as meta, queue and flag fields
  typedef union packed {
    logic [USER_W-1:0] raw;
    struct packed {
      logic [55:0] meta;
      logic [14:0] queue;
      logic        flag;
    } f;
  } flc_tuser_u;

endpackage

// ==== source/flc_stream_if.sv ====
/*
 * Client data stream
 * valid/ready handshake carrying one 512-bit beat with
 * byte enables, end-of-packet and user sideband
 */
interface flc_stream_if;

  logic                        valid;
  logic                        ready;
  logic [flc_pkg::DATA_W-1:0]  data;
  logic [flc_pkg::KEEP_W-1:0]  keep;
  logic                        last;
  logic [flc_pkg::USER_W-1:0]  user;

  modport source (
    output valid, data, keep, last, user,
    input  ready
  );

  modport sink (
    input  valid, data, keep, last, user,
    output ready
  );

endinterface

// ==== source/flc_apb_if.sv ====
/*
 * APB link to the gateway memory
 * Setup cycle then access cycle, completion on pready
 */
interface flc_apb_if;

  logic                              psel;
  logic                              penable;
  logic                              pwrite;
  logic [flc_pkg::APB_ADDR_W-1:0]    paddr;
  logic [flc_pkg::APB_DATA_W-1:0]    pwdata;
  logic [flc_pkg::APB_DATA_W/8-1:0]  pstrb;
  logic [flc_pkg::APB_DATA_W-1:0]    prdata;
  logic                              pready;
  logic                              pslverr;

  modport requester (
    output psel, penable, pwrite, paddr, pwdata, pstrb,
    input  prdata, pready, pslverr
  );

  modport completer (
    input  psel, penable, pwrite, paddr, pwdata, pstrb,
    output prdata, pready, pslverr
  );

endinterface

// ==== source/flc_user_loopback.sv ====
/*
 * Per-slice user loopback buffer
 * Beats from the connect block are queued and sent back on the
 * slice's transmit stream with the queue field of the sideband
 * cleared. Reports full and almost-full fill status.
 */
module flc_user_loopback #(
  parameter int FIFO_DEPTH   = 16,
  parameter int AFULL_MARGIN = 4
) (
  input  logic          pcie_user_clk,
  input  logic          rst,
  flc_stream_if.sink    rx,
  flc_stream_if.source  tx,
  output logic          rx_full,
  output logic          rx_afull
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam logic [CNT_W-1:0] FULL_LVL  = CNT_W'(FIFO_DEPTH);
  localparam logic [CNT_W-1:0] AFULL_LVL = CNT_W'(FIFO_DEPTH - AFULL_MARGIN);

  // Beat storage
  logic [flc_pkg::DATA_W-1:0]  data_mem [FIFO_DEPTH];
  logic [flc_pkg::KEEP_W-1:0]  keep_mem [FIFO_DEPTH];
  logic                        last_mem [FIFO_DEPTH];
  flc_pkg::flc_tuser_u         user_mem [FIFO_DEPTH];

  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                push;
  logic                pop;
  flc_pkg::flc_tuser_u in_user;
  flc_pkg::flc_tuser_u wr_user;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign push = rx.valid && rx.ready;
  assign pop  = tx.valid && tx.ready;

  // Sideband rewrite on the way in
  always_comb begin
    in_user.raw       = rx.user;
    wr_user           = in_user;
    wr_user.f.queue   = '0;
    wr_user.f.flag    = in_user.raw[flc_pkg::QUEUE_CLEAR_BIT];
  end

  always_ff @(posedge pcie_user_clk) begin
    if (push) begin
      data_mem[wr_ptr] <= rx.data;
      keep_mem[wr_ptr] <= rx.keep;
      last_mem[wr_ptr] <= rx.last;
      user_mem[wr_ptr] <= wr_user;
    end
  end

  always_ff @(posedge pcie_user_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head of queue goes straight out
  assign tx.valid = (count != '0);
  assign tx.data  = data_mem[rd_ptr];
  assign tx.keep  = keep_mem[rd_ptr];
  assign tx.last  = last_mem[rd_ptr];
  assign tx.user  = user_mem[rd_ptr].raw;

  assign rx.ready = (count < FULL_LVL);
  assign rx_full  = (count == FULL_LVL);
  assign rx_afull = (count >= AFULL_LVL);

  // Stalled beat must not change until the connect block takes it
  a_tx_hold: assert property (@(posedge pcie_user_clk) disable iff (rst)
    tx.valid && !tx.ready |=>
      tx.valid && $stable({tx.data, tx.keep, tx.last, tx.user}));

  a_fill_bound: assert property (@(posedge pcie_user_clk) disable iff (rst)
    count <= FULL_LVL);

endmodule

// ==== source/flc_gw_mem.sv ====
/*
 * Gateway memory, 1024 x 32
 * APB completer with byte strobes. Word index from paddr[11:2],
 * upper address bits alias.
 */
module flc_gw_mem (
  input  logic             pcie_user_clk,
  input  logic             rst,
  flc_apb_if.completer     apb
);

  localparam int BYTES = flc_pkg::APB_DATA_W / 8;

  logic [flc_pkg::APB_DATA_W-1:0] mem [flc_pkg::GW_WORDS];

  logic [flc_pkg::GW_ADDR_W-1:0] word_idx;
  logic                          setup_rd;
  logic                          access_wr;

  assign word_idx  = apb.paddr[flc_pkg::GW_ADDR_W+1:2];
  assign setup_rd  = apb.psel && !apb.penable && !apb.pwrite;
  assign access_wr = apb.psel && apb.penable && apb.pwrite;

  // Byte-merged write in the access cycle
  always_ff @(posedge pcie_user_clk) begin
    if (access_wr) begin
      for (int b = 0; b < BYTES; b++) begin
        if (apb.pstrb[b]) begin
          mem[word_idx][b*8 +: 8] <= apb.pwdata[b*8 +: 8];
        end
      end
    end
  end

  // Read data captured at the end of setup
  always_ff @(posedge pcie_user_clk) begin
    if (rst) begin
      apb.prdata <= '0;
    end else if (setup_rd) begin
      apb.prdata <= mem[word_idx];
    end
  end

  // No wait states
  assign apb.pready  = apb.psel && apb.penable;
  assign apb.pslverr = 1'b0;

  a_apb_setup: assert property (@(posedge pcie_user_clk) disable iff (rst)
    $rose(apb.penable) |-> apb.psel && $past(apb.psel));

endmodule

// ==== source/flc_example_top.sv ====
/*
 * FlexConnect example, user side
 * Two loopback client slices and the gateway memory,
 * with plain ports toward the connect block
 */
module flc_example_top #(
  parameter int FIFO_DEPTH   = 16,
  parameter int AFULL_MARGIN = 4
) (
  input  logic                              pcie_user_clk,
  input  logic                              rst,

  // Slice 0 from the connect block
  input  logic                              rx0_valid,
  output logic                              rx0_ready,
  input  logic [flc_pkg::DATA_W-1:0]        rx0_data,
  input  logic [flc_pkg::KEEP_W-1:0]        rx0_keep,
  input  logic                              rx0_last,
  input  logic [flc_pkg::USER_W-1:0]        rx0_user,
  // Slice 0 toward the connect block
  output logic                              tx0_valid,
  input  logic                              tx0_ready,
  output logic [flc_pkg::DATA_W-1:0]        tx0_data,
  output logic [flc_pkg::KEEP_W-1:0]        tx0_keep,
  output logic                              tx0_last,
  output logic [flc_pkg::USER_W-1:0]        tx0_user,
  output logic                              rx0_full,
  output logic                              rx0_afull,

  // Slice 1 from the connect block
  input  logic                              rx1_valid,
  output logic                              rx1_ready,
  input  logic [flc_pkg::DATA_W-1:0]        rx1_data,
  input  logic [flc_pkg::KEEP_W-1:0]        rx1_keep,
  input  logic                              rx1_last,
  input  logic [flc_pkg::USER_W-1:0]        rx1_user,
  // Slice 1 toward the connect block
  output logic                              tx1_valid,
  input  logic                              tx1_ready,
  output logic [flc_pkg::DATA_W-1:0]        tx1_data,
  output logic [flc_pkg::KEEP_W-1:0]        tx1_keep,
  output logic                              tx1_last,
  output logic [flc_pkg::USER_W-1:0]        tx1_user,
  output logic                              rx1_full,
  output logic                              rx1_afull,

  // Gateway
  input  logic                              apb_psel,
  input  logic                              apb_penable,
  input  logic                              apb_pwrite,
  input  logic [flc_pkg::APB_ADDR_W-1:0]    apb_paddr,
  input  logic [flc_pkg::APB_DATA_W-1:0]    apb_pwdata,
  input  logic [flc_pkg::APB_DATA_W/8-1:0]  apb_pstrb,
  output logic [flc_pkg::APB_DATA_W-1:0]    apb_prdata,
  output logic                              apb_pready,
  output logic                              apb_pslverr
);

  flc_stream_if rx0_if ();
  flc_stream_if tx0_if ();
  flc_stream_if rx1_if ();
  flc_stream_if tx1_if ();
  flc_apb_if    gw_if ();

  // Slice 0
  assign rx0_if.valid = rx0_valid;
  assign rx0_if.data  = rx0_data;
  assign rx0_if.keep  = rx0_keep;
  assign rx0_if.last  = rx0_last;
  assign rx0_if.user  = rx0_user;
  assign rx0_ready    = rx0_if.ready;

  assign tx0_valid    = tx0_if.valid;
  assign tx0_data     = tx0_if.data;
  assign tx0_keep     = tx0_if.keep;
  assign tx0_last     = tx0_if.last;
  assign tx0_user     = tx0_if.user;
  assign tx0_if.ready = tx0_ready;

  flc_user_loopback #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) flc_user_loopback_p0 (
    .pcie_user_clk (pcie_user_clk),
    .rst           (rst),
    .rx            (rx0_if.sink),
    .tx            (tx0_if.source),
    .rx_full       (rx0_full),
    .rx_afull      (rx0_afull)
  );

  // Slice 1
  assign rx1_if.valid = rx1_valid;
  assign rx1_if.data  = rx1_data;
  assign rx1_if.keep  = rx1_keep;
  assign rx1_if.last  = rx1_last;
  assign rx1_if.user  = rx1_user;
  assign rx1_ready    = rx1_if.ready;

  assign tx1_valid    = tx1_if.valid;
  assign tx1_data     = tx1_if.data;
  assign tx1_keep     = tx1_if.keep;
  assign tx1_last     = tx1_if.last;
  assign tx1_user     = tx1_if.user;
  assign tx1_if.ready = tx1_ready;

  flc_user_loopback #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) flc_user_loopback_p1 (
    .pcie_user_clk (pcie_user_clk),
    .rst           (rst),
    .rx            (rx1_if.sink),
    .tx            (tx1_if.source),
    .rx_full       (rx1_full),
    .rx_afull      (rx1_afull)
  );

  // Gateway memory
  assign gw_if.psel    = apb_psel;
  assign gw_if.penable = apb_penable;
  assign gw_if.pwrite  = apb_pwrite;
  assign gw_if.paddr   = apb_paddr;
  assign gw_if.pwdata  = apb_pwdata;
  assign gw_if.pstrb   = apb_pstrb;
  assign apb_prdata    = gw_if.prdata;
  assign apb_pready    = gw_if.pready;
  assign apb_pslverr   = gw_if.pslverr;

  flc_gw_mem flc_gw_mem_inst (
    .pcie_user_clk (pcie_user_clk),
    .rst           (rst),
    .apb           (gw_if.completer)
  );

endmodule

// ==== tb/flc_tb_checks.sv ====
/*
 * FlexConnect example scoreboard
 * Model queues for both loopback slices and a word model of the
 * gateway memory, compared against the DUT by concurrent assertions
 */
module flc_tb_checks #(
  parameter int FIFO_DEPTH   = 16,
  parameter int AFULL_MARGIN = 4
) (
  input logic                              pcie_user_clk,
  input logic                              rst,
  input logic [1:0]                        rx_valid, rx_ready, rx_last, rx_full, rx_afull,
  input logic [1:0]                        tx_valid, tx_ready, tx_last,
  input logic [1:0][flc_pkg::DATA_W-1:0]   rx_data, tx_data,
  input logic [1:0][flc_pkg::KEEP_W-1:0]   rx_keep, tx_keep,
  input logic [1:0][flc_pkg::USER_W-1:0]   rx_user, tx_user,
  input logic                              apb_psel, apb_penable, apb_pwrite,
  input logic                              apb_pready, apb_pslverr,
  input logic [flc_pkg::APB_ADDR_W-1:0]    apb_paddr,
  input logic [flc_pkg::APB_DATA_W-1:0]    apb_pwdata, apb_prdata,
  input logic [flc_pkg::APB_DATA_W/8-1:0]  apb_pstrb
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BEAT_W = flc_pkg::DATA_W + flc_pkg::KEEP_W + 1;

  string test_name = "none";
  int    errors = 0;
  logic [flc_pkg::APB_DATA_W-1:0] gw_model [int];

  // Expected sideband after loopback
  function automatic logic [flc_pkg::USER_W-1:0] loop_user(
    input logic [flc_pkg::USER_W-1:0] u
  );
    flc_pkg::flc_tuser_u w;
    w.raw       = u;
    w.raw[15:1] = '0;
    w.raw[0]    = u[flc_pkg::QUEUE_CLEAR_BIT];
    return w.raw;
  endfunction

  // full, almost full, ready
  function automatic logic [2:0] fill_flags(input int fill);
    return {fill == FIFO_DEPTH, fill >= FIFO_DEPTH - AFULL_MARGIN, fill < FIFO_DEPTH};
  endfunction

  function automatic logic [flc_pkg::APB_DATA_W-1:0] model_word(
    input logic [flc_pkg::APB_ADDR_W-1:0] addr
  );
    logic [flc_pkg::APB_DATA_W-1:0] w;
    w = 'x;
    if (gw_model.exists(int'(addr[flc_pkg::GW_ADDR_W+1:2]))) begin
      w = gw_model[int'(addr[flc_pkg::GW_ADDR_W+1:2])];
    end
    return w;
  endfunction

  a_reset_state: assert property (@(posedge pcie_user_clk)
    $fell(rst) |-> {tx_valid, rx_full, rx_afull, rx_ready} == 8'b00000011)
    else begin
      $display("MISMATCH %s reset flags expected %b actual %b", test_name, 8'b00000011,
        $sampled({tx_valid, rx_full, rx_afull, rx_ready}));
      errors++;
    end

  for (genvar s = 0; s < 2; s++) begin : slice
    logic [BEAT_W+flc_pkg::USER_W-1:0] q [$];
    logic [BEAT_W-1:0]                 head_beat;
    logic [flc_pkg::USER_W-1:0]        head_user;
    int                                fill;

    always @(posedge pcie_user_clk) begin
      if (rst) begin
        q.delete();
      end else begin
        if (rx_valid[s] && rx_ready[s]) begin
          q.push_back({rx_data[s], rx_keep[s], rx_last[s], loop_user(rx_user[s])});
        end
        if (tx_valid[s] && tx_ready[s] && q.size() > 0) begin
          void'(q.pop_front());
        end
      end
      fill = q.size();
      {head_beat, head_user} = (fill > 0) ? q[0] : 'x;
    end

    a_no_extra: assert property (@(posedge pcie_user_clk) disable iff (rst)
      tx_valid[s] |-> fill > 0)
      else begin
        $display("%s: slice %0d sent a beat it never received", test_name, s);
        errors++;
      end

    a_beat: assert property (@(posedge pcie_user_clk) disable iff (rst)
      tx_valid[s] && tx_ready[s] && fill > 0 |->
        {tx_data[s], tx_keep[s], tx_last[s]} == head_beat)
      else begin
        $display("MISMATCH %s slice %0d beat expected %h actual %h", test_name, s,
          $sampled(head_beat), $sampled({tx_data[s], tx_keep[s], tx_last[s]}));
        errors++;
      end

    a_user: assert property (@(posedge pcie_user_clk) disable iff (rst)
      tx_valid[s] && tx_ready[s] && fill > 0 |-> tx_user[s] == head_user)
      else begin
        $display("MISMATCH %s slice %0d user expected %h actual %h", test_name, s,
          $sampled(head_user), $sampled(tx_user[s]));
        errors++;
      end

    a_flags: assert property (@(posedge pcie_user_clk) disable iff (rst)
      {rx_full[s], rx_afull[s], rx_ready[s]} == fill_flags(fill))
      else begin
        $display("MISMATCH %s slice %0d flags expected %b actual %b", test_name, s,
          fill_flags($sampled(fill)), $sampled({rx_full[s], rx_afull[s], rx_ready[s]}));
        errors++;
      end
  end

  // Byte merge into the word model on each completed write
  always @(posedge pcie_user_clk) begin
    logic [flc_pkg::APB_DATA_W-1:0] w;
    if (!rst && apb_psel && apb_penable && apb_pready && apb_pwrite) begin
      w = model_word(apb_paddr);
      for (int b = 0; b < flc_pkg::APB_DATA_W / 8; b++) begin
        if (apb_pstrb[b]) begin
          w[b*8 +: 8] = apb_pwdata[b*8 +: 8];
        end
      end
      gw_model[int'(apb_paddr[flc_pkg::GW_ADDR_W+1:2])] = w;
    end
  end

  a_apb_done: assert property (@(posedge pcie_user_clk) disable iff (rst)
    apb_psel && apb_penable |-> apb_pready && !apb_pslverr)
    else begin
      $display("%s: APB access cycle ended without pready or with pslverr", test_name);
      errors++;
    end

  a_apb_read: assert property (@(posedge pcie_user_clk) disable iff (rst)
    apb_psel && apb_penable && !apb_pwrite |-> apb_prdata == model_word(apb_paddr))
    else begin
      $display("MISMATCH %s read expected %h actual %h", test_name,
        model_word($sampled(apb_paddr)), $sampled(apb_prdata));
      errors++;
    end

endmodule

// ==== tb/flc_example_tb.sv ====
/*
 * FlexConnect example testbench
 * Drives both loopback slices and the gateway memory; the checker
 * module next to the DUT does the comparing
 */
module flc_example_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 8;
  localparam int FIFO_DEPTH   = 16;
  localparam int AFULL_MARGIN = 4;
  localparam int RST_CYCLES   = 8;
  localparam int LOOP_BEATS   = 40;
  localparam int GW_TRIES     = 24;
  localparam int ALIAS_TRIES  = 6;
  localparam int UPPER_W      = flc_pkg::APB_ADDR_W - flc_pkg::GW_ADDR_W - 2;
  // Rough cycle count of all tests together
  localparam int TEST_CYCLES  = RST_CYCLES + 3 * LOOP_BEATS + 3 * FIFO_DEPTH
                              + 6 * GW_TRIES + 4 * ALIAS_TRIES;

  logic pcie_user_clk = 1'b0;
  logic rst = 1'b1;
  logic [1:0] rx_valid = '0, rx_last = '0, tx_ready = '0, hold_tx = '0;
  logic [1:0][flc_pkg::DATA_W-1:0] rx_data = '0;
  logic [1:0][flc_pkg::KEEP_W-1:0] rx_keep = '0;
  logic [1:0][flc_pkg::USER_W-1:0] rx_user = '0;
  wire  [1:0] rx_ready, rx_full, rx_afull, tx_valid, tx_last;
  wire  [1:0][flc_pkg::DATA_W-1:0] tx_data;
  wire  [1:0][flc_pkg::KEEP_W-1:0] tx_keep;
  wire  [1:0][flc_pkg::USER_W-1:0] tx_user;
  logic apb_psel = 1'b0, apb_penable = 1'b0, apb_pwrite = 1'b0;
  logic [flc_pkg::APB_ADDR_W-1:0] apb_paddr = '0;
  logic [flc_pkg::APB_DATA_W-1:0] apb_pwdata = '0;
  logic [flc_pkg::APB_DATA_W/8-1:0] apb_pstrb = '0;
  wire  [flc_pkg::APB_DATA_W-1:0] apb_prdata;
  wire  apb_pready, apb_pslverr;
  logic [31:0] lfsr = 32'h789;
  int tests_run = 0;
  int errors_before = 0;

  always #(CLK_PERIOD / 2) pcie_user_clk = ~pcie_user_clk;

  flc_example_top #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) flc_example_top_inst (
    .pcie_user_clk (pcie_user_clk),
    .rst           (rst),
    .rx0_valid     (rx_valid[0]),
    .rx0_ready     (rx_ready[0]),
    .rx0_data      (rx_data[0]),
    .rx0_keep      (rx_keep[0]),
    .rx0_last      (rx_last[0]),
    .rx0_user      (rx_user[0]),
    .tx0_valid     (tx_valid[0]),
    .tx0_ready     (tx_ready[0]),
    .tx0_data      (tx_data[0]),
    .tx0_keep      (tx_keep[0]),
    .tx0_last      (tx_last[0]),
    .tx0_user      (tx_user[0]),
    .rx0_full      (rx_full[0]),
    .rx0_afull     (rx_afull[0]),
    .rx1_valid     (rx_valid[1]),
    .rx1_ready     (rx_ready[1]),
    .rx1_data      (rx_data[1]),
    .rx1_keep      (rx_keep[1]),
    .rx1_last      (rx_last[1]),
    .rx1_user      (rx_user[1]),
    .tx1_valid     (tx_valid[1]),
    .tx1_ready     (tx_ready[1]),
    .tx1_data      (tx_data[1]),
    .tx1_keep      (tx_keep[1]),
    .tx1_last      (tx_last[1]),
    .tx1_user      (tx_user[1]),
    .rx1_full      (rx_full[1]),
    .rx1_afull     (rx_afull[1]),
    .apb_psel      (apb_psel),
    .apb_penable   (apb_penable),
    .apb_pwrite    (apb_pwrite),
    .apb_paddr     (apb_paddr),
    .apb_pwdata    (apb_pwdata),
    .apb_pstrb     (apb_pstrb),
    .apb_prdata    (apb_prdata),
    .apb_pready    (apb_pready),
    .apb_pslverr   (apb_pslverr)
  );

  flc_tb_checks #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) checks (.*);

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [flc_pkg::DATA_W-1:0] rand_bits(input int n);
    logic [flc_pkg::DATA_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  // Random back-pressure unless a slice is held
  always @(posedge pcie_user_clk) begin
    logic [flc_pkg::DATA_W-1:0] r;
    #1;
    r = rand_bits(2);
    tx_ready = ~hold_tx & r[1:0];
  end

  task automatic step();
    @(posedge pcie_user_clk);
    #1;
  endtask

  // Both slices at once with each beat held until accepted
  task automatic send_beats(input int n);
    int         left [2];
    logic [1:0] taken;
    left = '{n, n};
    while (left[0] > 0 || left[1] > 0) begin
      for (int s = 0; s < 2; s++) begin
        if (left[s] > 0 && !rx_valid[s]) begin
          rx_valid[s] = 1'b1;
          rx_data[s]  = rand_bits(flc_pkg::DATA_W);
          rx_keep[s]  = rand_bits(flc_pkg::KEEP_W);
          rx_last[s]  = rand_bits(1);
          rx_user[s]  = rand_bits(flc_pkg::USER_W);
        end
      end
      taken = rx_valid & rx_ready;
      step();
      for (int s = 0; s < 2; s++) begin
        if (taken[s]) begin
          left[s]--;
          rx_valid[s] = 1'b0;
        end
      end
    end
  endtask

  task automatic wait_drain();
    while (checks.slice[0].fill != 0 || checks.slice[1].fill != 0) begin
      step();
    end
  endtask

  task automatic apb_xfer(input logic write, input logic [flc_pkg::APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb);
    logic done;
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    apb_pwrite  = write;
    apb_paddr   = addr;
    apb_pwdata  = wdata;
    apb_pstrb   = strb;
    step();
    apb_penable = 1'b1;
    do begin
      @(posedge pcie_user_clk);
      done = apb_pready;
      #1;
    end while (!done);
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
  endtask

  task automatic start_test(input string name);
    checks.test_name = name;
    errors_before = checks.errors;
  endtask

  task automatic end_test();
    tests_run++;
    $display("%-12s done, %0d errors", checks.test_name, checks.errors - errors_before);
  endtask

  initial begin
    logic [flc_pkg::GW_ADDR_W-1:0] idx;
    logic [UPPER_W-1:0]            upper;
    start_test("reset");
    repeat (RST_CYCLES) step();
    rst = 1'b0;
    step();
    end_test();

    // Also covers the sideband rewrite
    start_test("loopback");
    send_beats(LOOP_BEATS);
    wait_drain();
    end_test();

    start_test("backpressure");
    hold_tx = 2'b11;
    step();
    send_beats(FIFO_DEPTH);
    repeat (2) step();
    hold_tx = 2'b00;
    wait_drain();
    end_test();

    start_test("gateway");
    repeat (GW_TRIES) begin
      idx = rand_bits(flc_pkg::GW_ADDR_W);
      apb_xfer(1'b1, {{UPPER_W{1'b0}}, idx, 2'b00}, rand_bits(32), 4'hf);
      apb_xfer(1'b1, {{UPPER_W{1'b0}}, idx, 2'b00}, rand_bits(32), rand_bits(4));
      apb_xfer(1'b0, {{UPPER_W{1'b0}}, idx, 2'b00}, '0, '0);
    end
    end_test();

    start_test("alias");
    repeat (ALIAS_TRIES) begin
      idx   = rand_bits(flc_pkg::GW_ADDR_W);
      upper = rand_bits(UPPER_W) | 1'b1;
      apb_xfer(1'b1, {upper, idx, 2'b00}, rand_bits(32), 4'hf);
      apb_xfer(1'b0, {{UPPER_W{1'b0}}, idx, 2'b00}, '0, '0);
    end
    end_test();

    $display("%0d tests run, %0d errors", tests_run, checks.errors);
    if (checks.errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 4 * CLK_PERIOD);
    $display("Timeout, the tests did not finish within %0d cycles", TEST_CYCLES * 4);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== sources.f ====
source/flc_pkg.sv
source/flc_stream_if.sv
source/flc_apb_if.sv
source/flc_user_loopback.sv
source/flc_gw_mem.sv
source/flc_example_top.sv
tb/flc_tb_checks.sv
tb/flc_example_tb.sv

// ==== Bender.yml ====
package:
  name: flc_example

sources:
  - files:
      - source/flc_pkg.sv
      - source/flc_stream_if.sv
      - source/flc_apb_if.sv
      - source/flc_user_loopback.sv
      - source/flc_gw_mem.sv
      - source/flc_example_top.sv
  - target: test
    files:
      - tb/flc_tb_checks.sv
      - tb/flc_example_tb.sv
